// File: bench/tb_centroid_report.sv
// Directed testbench for the centroid report unit
// A UART model answers each DE with a TX_BUSY pulse of fixed or random length
// Expected lines are built from the driven sums, one line is 20 bytes
// Every wait is bounded; a timeout ends the run
module tb_centroid_report;
    timeunit 1ns;
    timeprecision 100ps;

    import report_pkg::*;

    localparam int LINE_LEN   = 20;
    localparam int FIXED_BUSY = 3;
    localparam int WAIT_LIMIT = 4000;

    logic    CLK;
    logic    RST_N;
    logic    TRIG;
    logic    OUT_SEL;
    logic    TX_BUSY = 1'b0;
    s_sum_t  S_SUM;
    xy_sum_t SX_SUM;
    xy_sum_t SY_SUM;
    xy_sum_t QSX_SUM;
    xy_sum_t QSY_SUM;
    logic    DE;
    char_t   DATA;
    logic    BUSY;

    integer     seed = 32079;
    int         errors = 0;
    int         monitor_errors = 0;
    int         tests = 0;
    logic [7:0] captured [$];
    logic [7:0] expected [$];
    logic       rand_busy = 1'b0;
    int         busy_len_tab [LINE_LEN];
    int         busy_left = 0;
    logic       de_prev = 1'b0;
    logic       timed_out = 1'b0;

    centroid_report #(.MAX_CHARS(XY_DIGITS)) dut0 (
        .CLK     (CLK),
        .RST_N   (RST_N),
        .TRIG    (TRIG),
        .OUT_SEL (OUT_SEL),
        .TX_BUSY (TX_BUSY),
        .S_SUM   (S_SUM),
        .SX_SUM  (SX_SUM),
        .SY_SUM  (SY_SUM),
        .QSX_SUM (QSX_SUM),
        .QSY_SUM (QSY_SUM),
        .DE      (DE),
        .DATA    (DATA),
        .BUSY    (BUSY)
    );

    always #2 CLK = ~CLK;

    // --------------------
    // UART model, takes DATA while DE is high and it is free
    always @(posedge CLK) begin
        de_prev <= DE;
        assert (!(DE && !de_prev && TX_BUSY)) else begin
            $display("DE rose while TX_BUSY was high at %0t", $time);
            monitor_errors++;
        end
        if (busy_left > 0) begin
            busy_left <= busy_left - 1;
            if (busy_left == 1) begin
                TX_BUSY <= 1'b0;
            end
        end else if (DE && !TX_BUSY) begin
            captured.push_back(DATA);
            TX_BUSY   <= 1'b1;
            busy_left <= rand_busy ? busy_len_tab[captured.size() % LINE_LEN] : FIXED_BUSY;
        end
    end

    // Closes the run once a wait has given up
    initial begin
        wait (timed_out);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic int total_errors();
        return errors + monitor_errors;
    endfunction

    function automatic logic [7:0] hex_digit(input logic [3:0] nibble);
        string digits = "0123456789ABCDEF";
        return digits[int'(nibble)];
    endfunction

    // S, then the two selected values, then line feed
    function automatic void build_line(input s_sum_t s,
                                       input xy_sum_t x,
                                       input xy_sum_t y);
        expected.delete();
        for (int i = 4; i >= 0; i--) begin
            expected.push_back(hex_digit(s[4*i +: 4]));
        end
        for (int i = 6; i >= 0; i--) begin
            expected.push_back(hex_digit(x[4*i +: 4]));
        end
        for (int i = 6; i >= 0; i--) begin
            expected.push_back(hex_digit(y[4*i +: 4]));
        end
        expected.push_back(8'h0A);
    endfunction

    task automatic drive_sums(input s_sum_t s, input xy_sum_t sx,
                              input xy_sum_t sy, input xy_sum_t qsx,
                              input xy_sum_t qsy, input logic sel);
        S_SUM   <= s;
        SX_SUM  <= sx;
        SY_SUM  <= sy;
        QSX_SUM <= qsx;
        QSY_SUM <= qsy;
        OUT_SEL <= sel;
    endtask

    task automatic pulse_trigger();
        TRIG <= 1'b1;
        @(posedge CLK);
        TRIG <= 1'b0;
    endtask

    // Hand the end of the run to the closing block and park this flow
    task automatic stall_on_timeout();
        timed_out = 1'b1;
        forever @(posedge CLK);
    endtask

    task automatic wait_busy(input logic level, input string name);
        int cycles;
        cycles = 0;
        while (BUSY !== level && cycles < WAIT_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        if (BUSY !== level) begin
            $display("Timeout in %s: BUSY never went to %0b", name, level);
            stall_on_timeout();
        end
    endtask

    task automatic wait_bytes(input int count, input string name);
        int cycles;
        cycles = 0;
        while (captured.size() < count && cycles < WAIT_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        if (captured.size() < count) begin
            $display("Timeout in %s: only %0d bytes reached the UART", name, captured.size());
            stall_on_timeout();
        end
    endtask

    task automatic compare_line(input string name, input int first);
        assert (captured.size() - first == LINE_LEN) else begin
            $display("Mismatch %s byte count: expected %0d actual %0d",
                     name, LINE_LEN, captured.size() - first);
            errors++;
        end
        for (int i = 0; i < LINE_LEN; i++) begin
            if (first + i < captured.size()) begin
                assert (captured[first + i] == expected[i]) else begin
                    $display("Mismatch %s byte %0d: expected %02h actual %02h",
                             name, i, expected[i], captured[first + i]);
                    errors++;
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("Test %s finished with %0d error(s)", name, total_errors() - errs_before);
    endtask

    // One full line from trigger to BUSY low
    task automatic send_line(input string name, input s_sum_t s,
                             input xy_sum_t sx, input xy_sum_t sy,
                             input xy_sum_t qsx, input xy_sum_t qsy,
                             input logic sel);
        int first;
        first = captured.size();
        build_line(s, sel ? qsx : sx, sel ? qsy : sy);
        @(posedge CLK);
        drive_sums(s, sx, sy, qsx, qsy, sel);
        pulse_trigger();
        wait_busy(1'b1, name);
        wait_busy(1'b0, name);
        compare_line(name, first);
    endtask

    // --------------------
    // Tests
    task automatic reset_outputs();
        int errs_before;
        errs_before = total_errors();
        for (int i = 0; i < 24; i++) begin
            @(posedge CLK);
            if (i == 15) begin
                RST_N <= 1'b1;
            end
            // First edge still shows power-up values
            if (i > 0) begin
                assert (DE === 1'b0 && BUSY === 1'b0 && DATA === 8'hFF) else begin
                    $display("Mismatch reset: expected DE/BUSY/DATA 0/0/ff actual %b/%b/%02h",
                             DE, BUSY, DATA);
                    errors++;
                end
            end
        end
        report_test("reset", errs_before);
    endtask

    task automatic snapshot_hold();
        int errs_before;
        int first;
        errs_before = total_errors();
        first = captured.size();
        build_line(20'h1A2B3, 28'h0C0FFEE, 28'h7654321);
        @(posedge CLK);
        drive_sums(20'h1A2B3, 28'h0C0FFEE, 28'h7654321, 28'hAAAAAAA, 28'h5555555, 1'b0);
        pulse_trigger();
        wait_busy(1'b1, "snapshot_hold");
        drive_sums(20'hFFFFF, 28'h1111111, 28'h2222222, 28'h3333333, 28'h4444444, 1'b1);
        wait_bytes(first + 6, "snapshot_hold");
        @(posedge CLK);
        pulse_trigger();
        wait_busy(1'b0, "snapshot_hold");
        // Quiet window, a second line would start well inside it
        repeat (100) @(posedge CLK);
        assert (BUSY === 1'b0) else begin
            $display("snapshot_hold: a second line started after the mid-line trigger");
            errors++;
        end
        compare_line("snapshot_hold", first);
        report_test("snapshot_hold", errs_before);
    endtask

    task automatic back_pressure();
        int         errs_before;
        logic [31:0] r [6];
        logic [31:0] len_r;
        errs_before = total_errors();
        rand_busy = 1'b1;
        for (int line = 0; line < 8; line++) begin
            for (int i = 0; i < LINE_LEN; i++) begin
                len_r = $random(seed);
                busy_len_tab[i] = 1 + int'(len_r % 32'd40);
            end
            for (int i = 0; i < 6; i++) begin
                r[i] = $random(seed);
            end
            send_line($sformatf("back_pressure_%0d", line), r[0][19:0], r[1][27:0],
                      r[2][27:0], r[3][27:0], r[4][27:0], r[5][0]);
        end
        rand_busy = 1'b0;
        report_test("back_pressure", errs_before);
    endtask

    initial begin
        int errs_before;
        CLK = 1'b0;
        RST_N   <= 1'b0;
        TRIG    <= 1'b0;
        drive_sums('0, '0, '0, '0, '0, 1'b0);
        reset_outputs();

        errs_before = total_errors();
        send_line("sum_line", 20'hFEDCB, 28'h0123456, 28'h89ABCDE, 28'hF0E1D2C, 28'h3B4A596, 1'b0);
        report_test("sum_line", errs_before);

        errs_before = total_errors();
        send_line("quotient_line", 20'hFEDCB, 28'h0123456, 28'h89ABCDE, 28'hF0E1D2C,
                  28'h3B4A596, 1'b1);
        report_test("quotient_line", errs_before);

        snapshot_hold();
        back_pressure();

        $display("Tests run: %0d, errors: %0d", tests, total_errors());
        if (total_errors() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: rtl/centroid_report.sv
// Eye tracker report unit: one hex text line per trigger to a UART
// Line is S (5 digits), SX/SY or QSX/QSY (7 digits each), then 0x0A
// OUT_SEL picks the quotient pair when high
// Sums and OUT_SEL are sampled two clocks after TRIG rises
// BUSY falls when the line is complete; triggers during a line are dropped
module centroid_report #(
    parameter int MAX_CHARS = report_pkg::XY_DIGITS
) (
    input  logic                CLK,
    input  logic                RST_N,
    input  logic                TRIG,
    input  logic                OUT_SEL,
    input  logic                TX_BUSY,
    input  report_pkg::s_sum_t  S_SUM,
    input  report_pkg::xy_sum_t SX_SUM,
    input  report_pkg::xy_sum_t SY_SUM,
    input  report_pkg::xy_sum_t QSX_SUM,
    input  report_pkg::xy_sum_t QSY_SUM,
    output logic                DE,
    output report_pkg::char_t   DATA,
    output logic                BUSY
);
    import report_pkg::*;

    // Byte link
    logic  byte_load;
    char_t tx_byte;
    logic  byte_done;

    snapshot_if snap_bus ();

    report_snapshot u_snapshot (
        .CLK     (CLK),
        .RST_N   (RST_N),
        .trig    (TRIG),
        .out_sel (OUT_SEL),
        .s_sum   (S_SUM),
        .sx_sum  (SX_SUM),
        .sy_sum  (SY_SUM),
        .qsx_sum (QSX_SUM),
        .qsy_sum (QSY_SUM),
        .snap    (snap_bus.snap)
    );

    report_sequencer #(.MAX_CHARS(MAX_CHARS)) u_sequencer (
        .CLK     (CLK),
        .RST_N   (RST_N),
        .snap    (snap_bus.seq),
        .load    (byte_load),
        .tx_byte (tx_byte),
        .done    (byte_done),
        .busy    (BUSY)
    );

    tx_pacer u_pacer (
        .CLK     (CLK),
        .RST_N   (RST_N),
        .load    (byte_load),
        .tx_byte (tx_byte),
        .done    (byte_done),
        .de      (DE),
        .data    (DATA),
        .tx_busy (TX_BUSY)
    );

endmodule

// File: rtl/hex_encoder.sv
// Unsigned value to upper-case ASCII hex, most significant digit first
// text[DIGITS-1] holds the leading digit; a narrow value is zero padded
// A value wider than 4*DIGITS bits loses its upper bits
module hex_encoder #(
    parameter type value_t = report_pkg::s_sum_t,
    parameter int  DIGITS  = ($bits(value_t) + 3) / 4
) (
    input  value_t                         value,
    output report_pkg::char_t [DIGITS-1:0] text
);
    import report_pkg::*;

    localparam int PAD_WIDTH = 4 * DIGITS;

    logic [PAD_WIDTH-1:0] padded;

    // '0'..'9' then 'A'..'F'
    function automatic char_t to_ascii(input logic [3:0] nibble);
        if (nibble < 4'd10) begin
            return 8'h30 + {4'h0, nibble};
        end
        return 8'h37 + {4'h0, nibble};
    endfunction

    assign padded = PAD_WIDTH'(value);

    always_comb begin
        for (int i = 0; i < DIGITS; i++) begin
            text[i] = to_ascii(padded[4*i +: 4]);
        end
    end

endmodule

// File: rtl/report_pkg.sv
// Shared widths, types and characters of the centroid report unit
// All sums are unsigned; digit counts round up to whole nibbles
// Field codes are fixed at 3 bits
package report_pkg;

    // --------------------
    // Widths
    localparam int S_WIDTH    = 20;
    localparam int XY_WIDTH   = 28;
    localparam int CHAR_WIDTH = 8;

    // --------------------
    // Payload types
    typedef logic [S_WIDTH-1:0]    s_sum_t;
    typedef logic [XY_WIDTH-1:0]   xy_sum_t;
    typedef logic [CHAR_WIDTH-1:0] char_t;

    // Hex digits per field
    localparam int S_DIGITS  = (S_WIDTH + 3) / 4;
    localparam int XY_DIGITS = (XY_WIDTH + 3) / 4;

    // --------------------
    // Sequencer fields, in line order
    typedef enum logic [2:0] {
        FIELD_IDLE = 3'd0,
        FIELD_S    = 3'd1,
        FIELD_X    = 3'd2,
        FIELD_Y    = 3'd3,
        FIELD_LF   = 3'd4
    } field_e;

    // --------------------
    // Characters
    localparam char_t CHAR_LF   = 8'h0A;
    localparam char_t CHAR_IDLE = 8'hFF;

endpackage

// File: rtl/report_sequencer.sv
// Field FSM for one report line: S, X, Y, then a line feed
// One byte is handed to the pacer per done; the first needs no done
// MAX_CHARS must cover the longest field (XY_DIGITS)
// busy follows the field register and drops one clock after the last done
module report_sequencer #(
    parameter int MAX_CHARS = report_pkg::XY_DIGITS
) (
    input  logic              CLK,
    input  logic              RST_N,
    snapshot_if.seq           snap,
    output logic              load,
    output report_pkg::char_t tx_byte,
    input  logic              done,
    output logic              busy
);
    import report_pkg::*;

    localparam int CNT_WIDTH = $clog2(MAX_CHARS + 1);

    typedef logic [CNT_WIDTH-1:0]  count_t;
    typedef char_t [MAX_CHARS-1:0] text_t;

    field_e                  field_q;
    field_e                  next_field;
    count_t                  count_q;
    count_t                  next_count;
    text_t                   shift_q;
    text_t                   next_text;
    char_t [S_DIGITS-1:0]    s_text;
    char_t [XY_DIGITS-1:0]   x_text;
    char_t [XY_DIGITS-1:0]   y_text;
    logic                    step;
    logic                    from_shift;

    hex_encoder #(.value_t(s_sum_t), .DIGITS(S_DIGITS)) u_enc_s (
        .value (snap.s_val),
        .text  (s_text)
    );

    hex_encoder #(.value_t(xy_sum_t), .DIGITS(XY_DIGITS)) u_enc_x (
        .value (snap.x_val),
        .text  (x_text)
    );

    hex_encoder #(.value_t(xy_sum_t), .DIGITS(XY_DIGITS)) u_enc_y (
        .value (snap.y_val),
        .text  (y_text)
    );

    // --------------------
    // Next field and its text, leading character at the top
    always_comb begin
        next_field = FIELD_IDLE;
        next_text  = {MAX_CHARS{CHAR_IDLE}};
        next_count = '0;
        case (field_q)
            FIELD_IDLE: begin
                next_field = FIELD_S;
                next_text[MAX_CHARS-1 -: S_DIGITS] = s_text;
                next_count = count_t'(S_DIGITS - 1);
            end
            FIELD_S: begin
                next_field = FIELD_X;
                next_text[MAX_CHARS-1 -: XY_DIGITS] = x_text;
                next_count = count_t'(XY_DIGITS - 1);
            end
            FIELD_X: begin
                next_field = FIELD_Y;
                next_text[MAX_CHARS-1 -: XY_DIGITS] = y_text;
                next_count = count_t'(XY_DIGITS - 1);
            end
            FIELD_Y: begin
                next_field = FIELD_LF;
                next_text[MAX_CHARS-1] = CHAR_LF;
            end
            default: begin
                next_field = FIELD_IDLE;
            end
        endcase
    end

    // Start opens a line, done moves it on
    assign step       = (field_q == FIELD_IDLE) ? snap.start : done;
    assign from_shift = (count_q != '0);

    assign snap.idle = (field_q == FIELD_IDLE);
    assign busy      = (field_q != FIELD_IDLE);

    // --------------------
    // Control
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            field_q <= FIELD_IDLE;
            count_q <= '0;
            load    <= 1'b0;
        end else begin
            load <= 1'b0;
            if (step) begin
                if (from_shift) begin
                    count_q <= count_q - 1'b1;
                    load    <= 1'b1;
                end else begin
                    field_q <= next_field;
                    count_q <= next_count;
                    load    <= (next_field != FIELD_IDLE);
                end
            end
        end
    end

    // Characters
    always_ff @(posedge CLK) begin
        if (step) begin
            if (from_shift) begin
                tx_byte <= shift_q[MAX_CHARS-1];
                shift_q <= {shift_q[MAX_CHARS-2:0], CHAR_IDLE};
            end else begin
                tx_byte <= next_text[MAX_CHARS-1];
                shift_q <= {next_text[MAX_CHARS-2:0], CHAR_IDLE};
            end
        end
    end

    a_count_range : assert property (
        @(posedge CLK) disable iff (!RST_N)
        count_q <= MAX_CHARS
    ) else $error("character count above MAX_CHARS");

endmodule

// File: rtl/report_snapshot.sv
// Trigger delay, rising edge detect and capture of the report sums
// Sums and out_sel are sampled on the same edge that raises start,
// two clocks after TRIG rises; they must be stable until then
// A rising edge seen while a line is in progress is dropped
module report_snapshot (
    input  logic                CLK,
    input  logic                RST_N,
    input  logic                trig,
    input  logic                out_sel,
    input  report_pkg::s_sum_t  s_sum,
    input  report_pkg::xy_sum_t sx_sum,
    input  report_pkg::xy_sum_t sy_sum,
    input  report_pkg::xy_sum_t qsx_sum,
    input  report_pkg::xy_sum_t qsy_sum,
    snapshot_if.snap            snap
);

    logic trig_d;
    logic trig_dd;
    logic trig_rise;
    logic capture;

    assign trig_rise = trig_d && !trig_dd;
    assign capture   = trig_rise && snap.idle;

    // --------------------
    // Delay and edge detect
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            trig_d     <= 1'b0;
            trig_dd    <= 1'b0;
            snap.start <= 1'b0;
        end else begin
            trig_d     <= trig;
            trig_dd    <= trig_d;
            snap.start <= capture;
        end
    end

    // --------------------
    // Held values for the whole line
    always_ff @(posedge CLK) begin
        if (capture) begin
            snap.s_val <= s_sum;
            // Quotient pair when out_sel is high
            snap.x_val <= out_sel ? qsx_sum : sx_sum;
            snap.y_val <= out_sel ? qsy_sum : sy_sum;
        end
    end

    // Sequencer must still be idle while it sees start
    a_start_when_idle : assert property (
        @(posedge CLK) disable iff (!RST_N)
        snap.start |-> snap.idle
    ) else $error("start raised while a line is in progress");

endmodule

// File: rtl/snapshot_if.sv
// Captured sums plus the start / idle pair between capture and sequencer
// Values are stable from the start pulse until idle returns high
interface snapshot_if;
    import report_pkg::*;

    logic    start;
    s_sum_t  s_val;
    xy_sum_t x_val;
    xy_sum_t y_val;
    logic    idle;

    modport snap (
        output start,
        output s_val,
        output x_val,
        output y_val,
        input  idle
    );

    modport seq (
        input  start,
        input  s_val,
        input  x_val,
        input  y_val,
        output idle
    );

endinterface

// File: rtl/tx_pacer.sv
// Byte handshake with an external UART transmitter
// DE is held from the clock after load until TX_BUSY is seen rising,
// then done pulses once TX_BUSY is seen low again
// Only one byte may be in flight; a UART that never raises busy stalls here
module tx_pacer (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              load,
    input  report_pkg::char_t tx_byte,
    output logic              done,
    output logic              de,
    output report_pkg::char_t data,
    input  logic              tx_busy
);
    import report_pkg::*;

    logic busy_q;
    logic busy_rise;
    logic wait_fall;
    logic pending;

    assign busy_rise = tx_busy && !busy_q;
    assign pending   = de || wait_fall;

    // --------------------
    // Present, wait for busy, wait for release
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            busy_q    <= 1'b0;
            de        <= 1'b0;
            wait_fall <= 1'b0;
            done      <= 1'b0;
            data      <= CHAR_IDLE;
        end else begin
            busy_q <= tx_busy;
            done   <= 1'b0;
            if (load) begin
                de   <= 1'b1;
                data <= tx_byte;
            end else if (de && busy_rise) begin
                // UART has taken the byte
                de        <= 1'b0;
                wait_fall <= 1'b1;
            end else if (wait_fall && !tx_busy) begin
                wait_fall <= 1'b0;
                done      <= 1'b1;
            end
        end
    end

    // Sequencer waits for done before the next byte
    a_no_overlap : assert property (
        @(posedge CLK) disable iff (!RST_N)
        load |-> !pending
    ) else $error("byte loaded while previous byte still pending");

endmodule

// File: run.sh
#!/bin/sh
# Build and run the centroid report testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_centroid_report
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_centroid_report > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    exit 0
fi
echo "Simulation reported failures"
exit 1

// File: src.f
rtl/report_pkg.sv
rtl/snapshot_if.sv
rtl/report_snapshot.sv
rtl/hex_encoder.sv
rtl/report_sequencer.sv
rtl/tx_pacer.sv
rtl/centroid_report.sv
bench/tb_centroid_report.sv
